// File: include/keynsham_defs.svh
`ifndef KEYNSHAM_DEFS_SVH
`define KEYNSHAM_DEFS_SVH

// upper 20 address bits of each 4 KiB window in the memory map
`define KEYNSHAM_RAM_BASE        20'h00000
`define KEYNSHAM_UART_BASE       20'h80000

// on-chip RAM depth in 32-bit words
`define KEYNSHAM_RAM_WORDS       1024

// clocks per UART bit are kept small so frames are short in simulation
`define KEYNSHAM_UART_DIV        8

// UART register offsets within its window
`define KEYNSHAM_UART_DATA_OFS   12'h000
`define KEYNSHAM_UART_STATUS_OFS 12'h004

`endif

// File: hw/keynsham_pkg.sv
package keynsham_pkg;

  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
  } uart_tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } uart_rx_state_e;

  // result of the data-bus address decode
  typedef enum logic [1:0] {
    REGION_RAM  = 2'd0,
    REGION_UART = 2'd1,
    REGION_NONE = 2'd2
  } bus_region_e;

endpackage

// File: hw/keynsham_ram.sv
`timescale 1ns/10ps
`include "keynsham_defs.svh"

module keynsham_ram (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic        i_access,
  input  logic        i_cs,
  input  logic [31:0] i_addr,
  input  logic        i_wr_en,
  input  logic [3:0]  i_bytesel,
  input  logic [31:0] i_wr_val,
  output logic [31:0] o_data,
  output logic        o_ack,
  output logic        o_error
);

  localparam int WORDS  = `KEYNSHAM_RAM_WORDS;
  localparam int ADDR_W = $clog2(WORDS);

  logic [31:0]       mem [WORDS];
  logic [ADDR_W-1:0] word_idx;
  logic              sel;

  // the low two address bits pick a lane and the bits above them index the word
  assign word_idx = i_addr[ADDR_W+1:2];
  assign sel      = i_access && i_cs;

  always_ff @(posedge clk) begin
    if (sel) begin
      if (i_wr_en) begin
        for (int lane = 0; lane < 4; lane++) begin
          if (i_bytesel[lane]) begin
            mem[word_idx][lane*8 +: 8] <= i_wr_val[lane*8 +: 8];
          end
        end
      end
      o_data <= mem[word_idx];
    end
  end

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack <= 1'b0;
    end else begin
      o_ack <= sel;
    end
  end

  // every word in the window exists so the RAM never faults
  assign o_error = 1'b0;

endmodule

// File: hw/keynsham_uart_tx.sv
`timescale 1ns/10ps
`include "keynsham_defs.svh"

module keynsham_uart_tx (
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_start,
  input  logic [7:0] i_byte,
  output logic       o_busy,
  output logic       o_tx
);
  import keynsham_pkg::*;

  localparam int DIV   = `KEYNSHAM_UART_DIV;
  localparam int CNT_W = $clog2(DIV);

  uart_tx_state_e   state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             bit_end;

  assign bit_end = (cnt == CNT_W'(DIV - 1));

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else if (state == TX_IDLE) begin
      cnt     <= '0;
      bit_idx <= '0;
      if (i_start) begin
        state <= TX_START;
      end
    end else if (!bit_end) begin
      cnt <= cnt + 1'b1;
    end else begin
      cnt <= '0;
      case (state)
        TX_START: state <= TX_DATA;
        TX_DATA: begin
          bit_idx <= bit_idx + 1'b1;
          if (bit_idx == 3'd7) begin
            state <= TX_STOP;
          end
        end
        default:  state <= TX_IDLE;
      endcase
    end
  end

  // data goes out LSB first
  always_ff @(posedge clk) begin
    if (state == TX_IDLE && i_start) begin
      shift <= i_byte;
    end else if (state == TX_DATA && bit_end) begin
      shift <= {1'b0, shift[7:1]};
    end
  end

  assign o_busy = (state != TX_IDLE);
  assign o_tx   = (state == TX_START) ? 1'b0 : (state == TX_DATA) ? shift[0] : 1'b1;

endmodule

// File: hw/keynsham_uart_rx.sv
`timescale 1ns/10ps
`include "keynsham_defs.svh"

module keynsham_uart_rx (
  input  logic       clk,
  input  logic       i_arst_n,
  input  logic       i_rx,
  input  logic       i_clear,
  output logic       o_valid,
  output logic [7:0] o_byte
);
  import keynsham_pkg::*;

  localparam int DIV   = `KEYNSHAM_UART_DIV;
  localparam int CNT_W = $clog2(DIV);

  uart_rx_state_e   state;
  logic [CNT_W-1:0] cnt;
  logic [2:0]       bit_idx;
  logic [7:0]       shift;
  logic             rx_meta;
  logic             rx_sync;
  logic             mid_start;
  logic             bit_end;
  logic             stop_mid;

  // line comes from another clock domain
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= i_rx;
      rx_sync <= rx_meta;
    end
  end

  // after the half-bit start check every full period lands mid-bit
  assign mid_start = (state == RX_START) && (cnt == CNT_W'(DIV / 2 - 1));
  assign bit_end   = (cnt == CNT_W'(DIV - 1));
  assign stop_mid  = (state == RX_STOP) && bit_end;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      cnt <= cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!rx_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          if (mid_start) begin
            cnt   <= '0;
            // a glitch shorter than half a bit is not a start bit
            state <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == RX_DATA && bit_end) begin
      shift <= {rx_sync, shift[7:1]};
    end
    if (stop_mid) begin
      o_byte <= shift;
    end
  end

  // a fresh byte wins over a clear in the same cycle
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
    end else if (stop_mid) begin
      o_valid <= 1'b1;
    end else if (i_clear) begin
      o_valid <= 1'b0;
    end
  end

endmodule

// File: hw/keynsham_uart.sv
`timescale 1ns/10ps
`include "keynsham_defs.svh"

module keynsham_uart (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic        i_access,
  input  logic        i_cs,
  input  logic [31:0] i_addr,
  input  logic        i_wr_en,
  input  logic [3:0]  i_bytesel,
  input  logic [31:0] i_wr_val,
  output logic [31:0] o_data,
  output logic        o_ack,
  output logic        o_error,
  input  logic        i_rx,
  output logic        o_tx
);

  logic       sel;
  logic       is_data;
  logic       is_status;
  logic       tx_start;
  logic       tx_busy;
  logic       rx_clear;
  logic       rx_valid;
  logic [7:0] rx_byte;
  logic       refuse;

  assign sel       = i_access && i_cs;
  assign is_data   = (i_addr[11:0] == `KEYNSHAM_UART_DATA_OFS);
  assign is_status = (i_addr[11:0] == `KEYNSHAM_UART_STATUS_OFS);

  // a data write while a frame is going out is refused rather than stalled
  assign refuse   = sel && is_data && i_wr_en && tx_busy;
  assign tx_start = sel && is_data && i_wr_en && i_bytesel[0] && !tx_busy;
  assign rx_clear = sel && is_data && !i_wr_en;

  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ack   <= 1'b0;
      o_error <= 1'b0;
    end else begin
      o_ack   <= sel && (is_data || is_status) && !refuse;
      o_error <= sel && ((!is_data && !is_status) || refuse);
    end
  end

  always_ff @(posedge clk) begin
    if (sel) begin
      if (is_status) begin
        o_data <= {30'h0, rx_valid, tx_busy};
      end else begin
        o_data <= {24'h0, rx_byte};
      end
    end
  end

  keynsham_uart_tx tx_i (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_start (tx_start),
    .i_byte  (i_wr_val[7:0]),
    .o_busy  (tx_busy),
    .o_tx    (o_tx)
  );

  keynsham_uart_rx rx_i (
    .clk     (clk),
    .i_arst_n(i_arst_n),
    .i_rx    (i_rx),
    .i_clear (rx_clear),
    .o_valid (rx_valid),
    .o_byte  (rx_byte)
  );

endmodule

// File: hw/keynsham_soc.sv
`timescale 1ns/10ps
`include "keynsham_defs.svh"

module keynsham_soc (
  input  logic        clk,
  input  logic        i_arst_n,
  input  logic        i_d_access,
  input  logic [31:0] i_d_addr,
  input  logic        i_d_wr_en,
  input  logic [3:0]  i_d_bytesel,
  input  logic [31:0] i_d_wr_val,
  output logic [31:0] o_d_data,
  output logic        o_d_ack,
  output logic        o_d_error,
  input  logic        i_uart_rx,
  output logic        o_uart_tx
);
  import keynsham_pkg::*;

  bus_region_e region;
  logic        ram_cs;
  logic        uart_cs;
  logic [31:0] ram_data;
  logic        ram_ack;
  logic        ram_error;
  logic [31:0] uart_data;
  logic        uart_ack;
  logic        uart_error;
  logic        none_error;

  // the old SDRAM ranges and anything else outside the RAM and UART0 windows are unmapped
  always_comb begin
    if (i_d_addr[31:12] == `KEYNSHAM_RAM_BASE) begin
      region = REGION_RAM;
    end else if (i_d_addr[31:12] == `KEYNSHAM_UART_BASE) begin
      region = REGION_UART;
    end else begin
      region = REGION_NONE;
    end
  end

  assign ram_cs  = (region == REGION_RAM);
  assign uart_cs = (region == REGION_UART);

  // unmapped accesses are answered here one cycle after the strobe like the slaves
  always_ff @(posedge clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      none_error <= 1'b0;
    end else begin
      none_error <= i_d_access && (region == REGION_NONE);
    end
  end

  // address is held until the response so the mux can follow the live decode
  always_comb begin
    case (region)
      REGION_RAM:  o_d_data = ram_data;
      REGION_UART: o_d_data = uart_data;
      default:     o_d_data = 32'h0;
    endcase
  end

  assign o_d_ack   = ram_ack | uart_ack;
  assign o_d_error = ram_error | uart_error | none_error;

  keynsham_ram ram_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_access (i_d_access),
    .i_cs     (ram_cs),
    .i_addr   (i_d_addr),
    .i_wr_en  (i_d_wr_en),
    .i_bytesel(i_d_bytesel),
    .i_wr_val (i_d_wr_val),
    .o_data   (ram_data),
    .o_ack    (ram_ack),
    .o_error  (ram_error)
  );

  keynsham_uart uart_i (
    .clk      (clk),
    .i_arst_n (i_arst_n),
    .i_access (i_d_access),
    .i_cs     (uart_cs),
    .i_addr   (i_d_addr),
    .i_wr_en  (i_d_wr_en),
    .i_bytesel(i_d_bytesel),
    .i_wr_val (i_d_wr_val),
    .o_data   (uart_data),
    .o_ack    (uart_ack),
    .o_error  (uart_error),
    .i_rx     (i_uart_rx),
    .o_tx     (o_uart_tx)
  );

endmodule

// File: testbench/keynsham_soc_chk.sv
`timescale 1ns/10ps

module keynsham_soc_chk (
  input logic                       clk,
  input logic                       i_arst_n,
  input logic                       i_d_access,
  input logic                       i_d_ack,
  input logic                       i_d_error,
  input logic                       i_uart_tx,
  input keynsham_pkg::bus_region_e  i_region
);
  import keynsham_pkg::*;

  // every strobe gets exactly one response pulse in the following cycle
  strobe_answered: assert property (@(posedge clk) disable iff (!i_arst_n)
    i_d_access |=> (i_d_ack ^ i_d_error))
    else $error("bus strobe was not answered by exactly one of ack and error");

  ack_error_exclusive: assert property (@(posedge clk) disable iff (!i_arst_n)
    !(i_d_ack && i_d_error))
    else $error("ack and error were high in the same cycle");

  no_spurious_response: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_d_ack || i_d_error) |-> $past(i_d_access))
    else $error("bus response without a strobe in the previous cycle");

  ram_acked: assert property (@(posedge clk) disable iff (!i_arst_n)
    (i_d_access && i_region == REGION_RAM) |=> (i_d_ack && !i_d_error))
    else $error("RAM access was not answered with an ack");

  // the serial line idles high while the UART is held in reset
  tx_idle_in_reset: assert property (@(posedge clk)
    !i_arst_n |-> i_uart_tx)
    else $error("uart tx line was low during reset");

endmodule

bind keynsham_soc keynsham_soc_chk chk_i (
  .clk       (clk),
  .i_arst_n  (i_arst_n),
  .i_d_access(i_d_access),
  .i_d_ack   (o_d_ack),
  .i_d_error (o_d_error),
  .i_uart_tx (o_uart_tx),
  .i_region  (region)
);

// File: testbench/keynsham_soc_tb.sv
`timescale 1ns/10ps
`include "keynsham_defs.svh"

module keynsham_soc_tb;

  localparam int FRAME_CLKS = 10 * `KEYNSHAM_UART_DIV;
  // one status poll takes one bus cycle and this bounds the wait near 12 frames
  localparam int POLL_LIMIT = 12 * FRAME_CLKS;
  localparam int RESP_LIMIT = 16;

  localparam logic [31:0] UART_DATA   = {`KEYNSHAM_UART_BASE, `KEYNSHAM_UART_DATA_OFS};
  localparam logic [31:0] UART_STATUS = {`KEYNSHAM_UART_BASE, `KEYNSHAM_UART_STATUS_OFS};

  logic        clk;
  logic        i_arst_n;
  logic        i_d_access;
  logic [31:0] i_d_addr;
  logic        i_d_wr_en;
  logic [3:0]  i_d_bytesel;
  logic [31:0] i_d_wr_val;
  logic [31:0] o_d_data;
  logic        o_d_ack;
  logic        o_d_error;
  wire         uart_line;

  logic [31:0] rsp_data;
  logic        rsp_ack;
  logic        rsp_error;
  integer      seed = 32'h5ee618cd;

  keynsham_soc keynsham_soc_i (
    .clk        (clk),
    .i_arst_n   (i_arst_n),
    .i_d_access (i_d_access),
    .i_d_addr   (i_d_addr),
    .i_d_wr_en  (i_d_wr_en),
    .i_d_bytesel(i_d_bytesel),
    .i_d_wr_val (i_d_wr_val),
    .o_d_data   (o_d_data),
    .o_d_ack    (o_d_ack),
    .o_d_error  (o_d_error),
    .i_uart_rx  (uart_line),
    .o_uart_tx  (uart_line)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      fail_now($sformatf("Mismatch in %s: expected %h, actual %h", name, exp, act));
    end
  endtask

  function automatic logic [31:0] apply_byte_lanes(input logic [31:0] old_word,
                                                   input logic [31:0] new_word,
                                                   input logic [3:0]  bsel);
    logic [31:0] result;
    result = old_word;
    for (int b = 0; b < 4; b++) begin
      if (bsel[b]) begin
        result[b*8 +: 8] = new_word[b*8 +: 8];
      end
    end
    return result;
  endfunction

  function automatic logic [31:0] ram_addr(input int idx);
    return {`KEYNSHAM_RAM_BASE, 12'(idx * 4)};
  endfunction

  // called on a falling edge and returns on the falling edge of the response cycle
  task automatic bus_access(input logic [31:0] addr, input logic wr,
                            input logic [3:0] bsel, input logic [31:0] wval);
    int waited;
    i_d_access  = 1'b1;
    i_d_addr    = addr;
    i_d_wr_en   = wr;
    i_d_bytesel = bsel;
    i_d_wr_val  = wval;
    @(negedge clk);
    i_d_access = 1'b0;
    waited = 1;
    while (!o_d_ack && !o_d_error && waited < RESP_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!o_d_ack && !o_d_error) begin
      fail_now($sformatf("no bus response to address %h within %0d cycles", addr, RESP_LIMIT));
    end
    rsp_data  = o_d_data;
    rsp_ack   = o_d_ack;
    rsp_error = o_d_error;
    check_value("response latency", 32'd1, 32'(waited));
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [3:0] bsel,
                           input logic [31:0] wval);
    bus_access(addr, 1'b1, bsel, wval);
  endtask

  task automatic bus_read(input logic [31:0] addr);
    bus_access(addr, 1'b0, 4'hf, 32'h0);
  endtask

  task automatic expect_ack(input string name);
    check_value({name, " ack"}, 32'd1, {31'h0, rsp_ack});
    check_value({name, " error"}, 32'd0, {31'h0, rsp_error});
  endtask

  task automatic expect_error(input string name);
    check_value({name, " error"}, 32'd1, {31'h0, rsp_error});
    check_value({name, " ack"}, 32'd0, {31'h0, rsp_ack});
  endtask

  task automatic poll_status(input string name, input logic [31:0] mask,
                             input logic [31:0] want);
    int polls;
    polls = 0;
    bus_read(UART_STATUS);
    while ((rsp_data & mask) != want && polls < POLL_LIMIT) begin
      bus_read(UART_STATUS);
      polls++;
    end
    if ((rsp_data & mask) != want) begin
      fail_now($sformatf("%s: UART status stuck at %h after %0d polls", name, rsp_data, polls));
    end
  endtask

  task automatic ram_word_round_trip();
    int          idx [8] = '{0, 1, 2, 100, 333, 511, 700, 1023};
    logic [31:0] written [8];
    for (int i = 0; i < 8; i++) begin
      written[i] = $random(seed);
      bus_write(ram_addr(idx[i]), 4'hf, written[i]);
      expect_ack("ram word write");
    end
    for (int i = 0; i < 8; i++) begin
      bus_read(ram_addr(idx[i]));
      expect_ack("ram word read");
      check_value("ram word round trip", written[i], rsp_data);
    end
  endtask

  task automatic ram_byte_lanes();
    logic [3:0]  lanes [4] = '{4'b0001, 4'b0100, 4'b1100, 4'b0011};
    logic [31:0] expected;
    logic [31:0] val;
    expected = $random(seed);
    bus_write(ram_addr(42), 4'hf, expected);
    expect_ack("ram lane base write");
    for (int i = 0; i < 4; i++) begin
      val = $random(seed);
      bus_write(ram_addr(42), lanes[i], val);
      expect_ack("ram lane write");
      expected = apply_byte_lanes(expected, val, lanes[i]);
      bus_read(ram_addr(42));
      expect_ack("ram lane read");
      check_value("ram byte lanes", expected, rsp_data);
    end
  endtask

  task automatic unmapped_access();
    logic [31:0] addrs [3] = '{32'h2000_0000, 32'h8000_1000, 32'h4000_0000};
    logic [31:0] val;
    for (int i = 0; i < 3; i++) begin
      val = $random(seed);
      bus_write(addrs[i], 4'hf, val);
      expect_error("unmapped write");
      bus_read(addrs[i]);
      expect_error("unmapped read");
      check_value("unmapped read data", 32'h0, rsp_data);
    end
  endtask

  task automatic uart_loopback();
    logic [31:0] val;
    val = $random(seed);
    bus_write(UART_DATA, 4'b0001, val);
    expect_ack("uart data write");
    poll_status("uart loopback", 32'h2, 32'h2);
    bus_read(UART_DATA);
    expect_ack("uart data read");
    check_value("uart loopback byte", {24'h0, val[7:0]}, rsp_data);
    bus_read(UART_STATUS);
    check_value("uart rx valid cleared", 32'h0, rsp_data & 32'h2);
  endtask

  task automatic uart_busy_refusal();
    logic [31:0] first;
    logic [31:0] second;
    first  = $random(seed);
    second = $random(seed);
    bus_write(UART_DATA, 4'b0001, first);
    expect_ack("uart first write");
    bus_write(UART_DATA, 4'b0001, second);
    expect_error("uart write while busy");
    bus_read(UART_STATUS);
    check_value("uart busy flag", 32'h1, rsp_data & 32'h1);
    // wait for the frame to finish and the byte to come back
    poll_status("uart busy frame", 32'h3, 32'h2);
    bus_read(UART_DATA);
    expect_ack("uart busy data read");
    check_value("uart first byte kept", {24'h0, first[7:0]}, rsp_data);
  endtask

  initial begin
    i_arst_n    = 1'b0;
    i_d_access  = 1'b0;
    i_d_addr    = 32'h0;
    i_d_wr_en   = 1'b0;
    i_d_bytesel = 4'h0;
    i_d_wr_val  = 32'h0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    i_arst_n = 1'b1;
    @(negedge clk);
    check_value("ack after reset", 32'd0, {31'h0, o_d_ack});
    check_value("error after reset", 32'd0, {31'h0, o_d_error});
    check_value("uart tx idle after reset", 32'd1, {31'h0, uart_line});
    ram_word_round_trip();
    ram_byte_lanes();
    unmapped_access();
    uart_loopback();
    uart_busy_refusal();
    $display("Testbench passed");
    $finish;
  end

endmodule

// File: sim.f
+incdir+include
hw/keynsham_pkg.sv
hw/keynsham_ram.sv
hw/keynsham_uart_tx.sv
hw/keynsham_uart_rx.sv
hw/keynsham_uart.sv
hw/keynsham_soc.sv
testbench/keynsham_soc_chk.sv
testbench/keynsham_soc_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the keynsham_soc testbench with Verilator.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -f sim.f \
  --top-module keynsham_soc_tb -Mdir "$OBJ" -o keynsham_soc_sim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

"./$OBJ/keynsham_soc_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Testbench failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
exit 0
